// ==== Bender.yml ====
package:
  name: nic_board

sources:
  - files:
      - rtl/board_cfg_pkg.sv
      - rtl/board_csr_pkg.sv
      - rtl/reset_sync.sv
      - rtl/pin_sync.sv
      - rtl/qsfpdd_i2c_pads.sv
      - rtl/board_csr.sv
      - rtl/nic_board_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_nic_board.sv

// ==== rtl/board_cfg_pkg.sv ====
// Board identity and structure constants
package board_cfg_pkg;

    // Identity words, read back by the host driver to match the image
    localparam logic [31:0] FPGA_ID   = 32'hC341_A0DD;
    localparam logic [31:0] BOARD_ID  = 32'h1172_B00E;
    localparam logic [31:0] BOARD_VER = 32'h0100_0000;

    // Firmware version fields
    localparam logic [7:0] FW_VER_MAJOR = 8'd0;
    localparam logic [7:0] FW_VER_MINOR = 8'd0;
    localparam logic [7:0] FW_VER_PATCH = 8'd1;
    localparam logic [7:0] FW_VER_META  = 8'd0;

    // Number of QSFP-DD cages on the board
    localparam int QSFPDD_CNT = 2;

    // Flops per bit on the module status and I2C readback pins
    localparam int PIN_SYNC_STAGES = 2;

    // Edges from reset deassertion to internal release
    localparam int RST_SYNC_STAGES = 3;

endpackage

// ==== rtl/board_csr.sv ====
// Board control and status registers
`timescale 1ns/1ps

module board_csr
    import board_cfg_pkg::*;
    import board_csr_pkg::*;
(
    input  logic                  pcie_clk,
    input  logic                  rst_n_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [WB_ADDR_W-1:0]  wb_adr_i,
    input  logic [WB_DATA_W-1:0]  wb_dat_i,
    input  logic [WB_SEL_W-1:0]   wb_sel_i,
    output logic [WB_DATA_W-1:0]  wb_dat_o,
    output logic                  wb_ack_o,
    input  logic [MOD_STAT_W-1:0] mod_stat_i,
    input  logic                  scl_i_i,
    input  logic                  sda_i_i,
    output logic [MOD_CTRL_W-1:0] mod_ctrl_o,
    output logic                  scl_o_o,
    output logic                  sda_o_o,
    output logic [LED_W-1:0]      led_o
);

    fw_ver_u                fw_ver;
    logic [WB_ADDR_W-1:0]   adr_word;
    logic                   wb_req;
    logic                   wr_en;
    logic [WB_DATA_W-1:0]   lane_mask;
    logic [WB_DATA_W-1:0]   stat_word;
    logic [WB_DATA_W-1:0]   i2c_word;
    logic [WB_DATA_W-1:0]   rd_data;
    logic [WB_DATA_W-1:0]   ctrl_next;
    logic [WB_DATA_W-1:0]   i2c_next;
    logic [WB_DATA_W-1:0]   led_next;
    logic [MOD_CTRL_W-1:0]  mod_ctrl_q;
    logic [1:0]             i2c_q;
    logic [LED_W-1:0]       led_q;
    logic                   ack_q;
    logic [WB_DATA_W-1:0]   dat_q;

    // Byte-lane merge limited to the writable bits of a register
    function automatic logic [WB_DATA_W-1:0] merge_lanes(
        input logic [WB_DATA_W-1:0] cur,
        input logic [WB_DATA_W-1:0] wdat,
        input logic [WB_DATA_W-1:0] lanes,
        input logic [WB_DATA_W-1:0] wmask
    );
        logic [WB_DATA_W-1:0] m;
        m = lanes & wmask;
        return (cur & ~m) | (wdat & m);
    endfunction

    always_comb begin
        fw_ver.f.major = FW_VER_MAJOR;
        fw_ver.f.minor = FW_VER_MINOR;
        fw_ver.f.patch = FW_VER_PATCH;
        fw_ver.f.meta  = FW_VER_META;
    end

    assign wb_req   = wb_cyc_i & wb_stb_i;
    assign adr_word = {wb_adr_i[WB_ADDR_W-1:2], 2'b00};
    // Writes land on the edge where the master sees ack
    assign wr_en    = wb_req & wb_we_i & ack_q;

    always_comb begin
        for (int i = 0; i < WB_SEL_W; i++) begin
            lane_mask[i*8 +: 8] = {8{wb_sel_i[i]}};
        end
    end

    // Status pins arrive two per module, spread to one byte per module
    always_comb begin
        stat_word = '0;
        for (int c = 0; c < QSFPDD_CNT; c++) begin
            stat_word[c*8 + STAT_MODPRS_L_BIT] = mod_stat_i[c*2 + STAT_MODPRS_L_BIT];
            stat_word[c*8 + STAT_INT_L_BIT]    = mod_stat_i[c*2 + STAT_INT_L_BIT];
        end
    end

    always_comb begin
        i2c_word                = '0;
        i2c_word[I2C_SCL_O_BIT] = i2c_q[I2C_SCL_O_BIT];
        i2c_word[I2C_SDA_O_BIT] = i2c_q[I2C_SDA_O_BIT];
        i2c_word[I2C_SCL_I_BIT] = scl_i_i;
        i2c_word[I2C_SDA_I_BIT] = sda_i_i;
    end

    assign ctrl_next = merge_lanes(WB_DATA_W'(mod_ctrl_q), wb_dat_i, lane_mask, CTRL_WR_MASK);
    assign i2c_next  = merge_lanes(WB_DATA_W'(i2c_q), wb_dat_i, lane_mask, I2C_WR_MASK);
    assign led_next  = merge_lanes(WB_DATA_W'(led_q), wb_dat_i, lane_mask, LED_WR_MASK);

    always_comb begin
        case (adr_word)
            REG_FPGA_ID:   rd_data = FPGA_ID;
            REG_FW_VER:    rd_data = fw_ver.raw;
            REG_BOARD_ID:  rd_data = BOARD_ID;
            REG_BOARD_VER: rd_data = BOARD_VER;
            REG_MOD_CTRL:  rd_data = WB_DATA_W'(mod_ctrl_q);
            REG_MOD_STAT:  rd_data = stat_word;
            REG_I2C:       rd_data = i2c_word;
            REG_LED:       rd_data = WB_DATA_W'(led_q);
            default:       rd_data = '0;
        endcase
    end

    always_ff @(posedge pcie_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q      <= 1'b0;
            mod_ctrl_q <= MOD_CTRL_RST[MOD_CTRL_W-1:0];
            i2c_q      <= I2C_RST[1:0];
            led_q      <= LED_RST[LED_W-1:0];
        end else begin
            // Single-cycle ack, low again for at least one cycle
            ack_q <= wb_req & ~ack_q;
            if (wr_en) begin
                case (adr_word)
                    REG_MOD_CTRL: mod_ctrl_q <= ctrl_next[MOD_CTRL_W-1:0];
                    REG_I2C:      i2c_q      <= i2c_next[1:0];
                    REG_LED:      led_q      <= led_next[LED_W-1:0];
                    default:      ;
                endcase
            end
        end
    end

    // Read data captured with ack, held while ack is high
    always_ff @(posedge pcie_clk) begin
        if (wb_req && !ack_q) begin
            dat_q <= rd_data;
        end
    end

    assign wb_dat_o   = dat_q;
    assign wb_ack_o   = ack_q;
    assign mod_ctrl_o = mod_ctrl_q;
    assign scl_o_o    = i2c_q[I2C_SCL_O_BIT];
    assign sda_o_o    = i2c_q[I2C_SDA_O_BIT];
    assign led_o      = led_q;

endmodule

// ==== rtl/board_csr_pkg.sv ====
// Board register map and field layout
package board_csr_pkg;

    // Wishbone classic slave sizes
    localparam int WB_ADDR_W = 8;
    localparam int WB_DATA_W = 32;
    localparam int WB_SEL_W  = 4;

    // Byte offsets, word aligned
    localparam logic [WB_ADDR_W-1:0] REG_FPGA_ID   = 8'h00;
    localparam logic [WB_ADDR_W-1:0] REG_FW_VER    = 8'h04;
    localparam logic [WB_ADDR_W-1:0] REG_BOARD_ID  = 8'h08;
    localparam logic [WB_ADDR_W-1:0] REG_BOARD_VER = 8'h0C;
    localparam logic [WB_ADDR_W-1:0] REG_MOD_CTRL  = 8'h10;
    localparam logic [WB_ADDR_W-1:0] REG_MOD_STAT  = 8'h14;
    localparam logic [WB_ADDR_W-1:0] REG_I2C       = 8'h18;
    localparam logic [WB_ADDR_W-1:0] REG_LED       = 8'h1C;

    // One byte per module, module 0 in byte 0
    localparam int CTRL_RESET_L_BIT  = 0;
    localparam int CTRL_LPMODE_BIT   = 1;
    localparam int CTRL_MODSEL_L_BIT = 2;
    localparam int STAT_MODPRS_L_BIT = 0;
    localparam int STAT_INT_L_BIT    = 1;

    localparam int I2C_SCL_O_BIT = 0;
    localparam int I2C_SDA_O_BIT = 1;
    localparam int I2C_SCL_I_BIT = 8;
    localparam int I2C_SDA_I_BIT = 9;

    // Control spans both module bytes, status has two pins per module
    localparam int MOD_CTRL_W = 11;
    localparam int MOD_STAT_W = 4;
    localparam int LED_W      = 4;

    // Bits that take writes, the rest read as zero
    localparam logic [WB_DATA_W-1:0] CTRL_WR_MASK = 32'h0000_0707;
    localparam logic [WB_DATA_W-1:0] I2C_WR_MASK  = 32'h0000_0003;
    localparam logic [WB_DATA_W-1:0] LED_WR_MASK  = 32'h0000_000F;

    // Deselected, out of reset, full power
    localparam logic [WB_DATA_W-1:0] MOD_CTRL_RST = 32'h0000_0505;
    localparam logic [WB_DATA_W-1:0] I2C_RST      = 32'h0000_0003;
    localparam logic [WB_DATA_W-1:0] LED_RST      = 32'h0000_0000;

    // Version word, raw or by field
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [7:0] major;
            logic [7:0] minor;
            logic [7:0] patch;
            logic [7:0] meta;
        } f;
    } fw_ver_u;

endpackage

// ==== rtl/nic_board_top.sv ====
// NIC board glue logic top level
`timescale 1ns/1ps

module nic_board_top
    import board_cfg_pkg::*;
    import board_csr_pkg::*;
(
    input  logic                  pcie_clk,
    input  logic                  rst_n_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [WB_ADDR_W-1:0]  wb_adr_i,
    input  logic [WB_DATA_W-1:0]  wb_dat_i,
    input  logic [WB_SEL_W-1:0]   wb_sel_i,
    output logic [WB_DATA_W-1:0]  wb_dat_o,
    output logic                  wb_ack_o,
    input  logic [QSFPDD_CNT-1:0] qsfpdd_modprs_l_i,
    input  logic [QSFPDD_CNT-1:0] qsfpdd_int_l_i,
    output wire  [QSFPDD_CNT-1:0] qsfpdd_modsel_l_o,
    output wire  [QSFPDD_CNT-1:0] qsfpdd_reset_l_o,
    output wire  [QSFPDD_CNT-1:0] qsfpdd_lpmode_o,
    inout  wire                   qsfpdd_i2c_scl,
    inout  wire                   qsfpdd_i2c_sda,
    output logic [LED_W-1:0]      fpga_led_o
);

    logic                  rst_sync_n;
    wire  [MOD_STAT_W-1:0] mod_stat_raw;
    logic [MOD_STAT_W-1:0] mod_stat_sync;
    logic [MOD_CTRL_W-1:0] mod_ctrl;
    logic                  scl_o;
    logic                  sda_o;
    logic                  scl_i;
    logic                  sda_i;

    reset_sync u_reset_sync (
        .pcie_clk     (pcie_clk),
        .rst_n_i      (rst_n_i),
        .rst_sync_n_o (rst_sync_n)
    );

    // Per-cage pin mapping, status two bits per cage, control one byte per cage
    for (genvar c = 0; c < QSFPDD_CNT; c++) begin : g_cage
        assign mod_stat_raw[c*2 + STAT_MODPRS_L_BIT] = qsfpdd_modprs_l_i[c];
        assign mod_stat_raw[c*2 + STAT_INT_L_BIT]    = qsfpdd_int_l_i[c];
        assign qsfpdd_reset_l_o[c]  = mod_ctrl[c*8 + CTRL_RESET_L_BIT];
        assign qsfpdd_lpmode_o[c]   = mod_ctrl[c*8 + CTRL_LPMODE_BIT];
        assign qsfpdd_modsel_l_o[c] = mod_ctrl[c*8 + CTRL_MODSEL_L_BIT];
    end

    pin_sync #(
        .WIDTH(MOD_STAT_W)
    ) u_stat_sync (
        .pcie_clk (pcie_clk),
        .rst_n_i  (rst_sync_n),
        .async_i  (mod_stat_raw),
        .sync_o   (mod_stat_sync)
    );

    qsfpdd_i2c_pads u_i2c_pads (
        .pcie_clk       (pcie_clk),
        .rst_n_i        (rst_sync_n),
        .scl_o_i        (scl_o),
        .sda_o_i        (sda_o),
        .scl_i_o        (scl_i),
        .sda_i_o        (sda_i),
        .qsfpdd_i2c_scl (qsfpdd_i2c_scl),
        .qsfpdd_i2c_sda (qsfpdd_i2c_sda)
    );

    board_csr u_board_csr (
        .pcie_clk   (pcie_clk),
        .rst_n_i    (rst_sync_n),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_adr_i   (wb_adr_i),
        .wb_dat_i   (wb_dat_i),
        .wb_sel_i   (wb_sel_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .mod_stat_i (mod_stat_sync),
        .scl_i_i    (scl_i),
        .sda_i_i    (sda_i),
        .mod_ctrl_o (mod_ctrl),
        .scl_o_o    (scl_o),
        .sda_o_o    (sda_o),
        .led_o      (fpga_led_o)
    );

endmodule

// ==== rtl/pin_sync.sv ====
// Multi-bit input synchronizer
`timescale 1ns/1ps

module pin_sync
    import board_cfg_pkg::*;
#(
    parameter int WIDTH = 4
) (
    input  logic             pcie_clk,
    input  logic             rst_n_i,
    input  logic [WIDTH-1:0] async_i,
    output logic [WIDTH-1:0] sync_o
);

    // Stage 0 takes the pins directly
    logic [PIN_SYNC_STAGES-1:0][WIDTH-1:0] sync_q;

    // Pins are pulled up on the board, so reset to the idle level
    always_ff @(posedge pcie_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q <= '1;
        end else begin
            sync_q <= {sync_q[PIN_SYNC_STAGES-2:0], async_i};
        end
    end

    assign sync_o = sync_q[PIN_SYNC_STAGES-1];

endmodule

// ==== rtl/qsfpdd_i2c_pads.sv ====
// QSFP-DD management I2C pads
`timescale 1ns/1ps

module qsfpdd_i2c_pads (
    input  logic pcie_clk,
    input  logic rst_n_i,
    input  logic scl_o_i,
    input  logic sda_o_i,
    output logic scl_i_o,
    output logic sda_i_o,
    inout  wire  qsfpdd_i2c_scl,
    inout  wire  qsfpdd_i2c_sda
);

    logic scl_rel_q;
    logic sda_rel_q;

    // Registered release bits keep the pad enables glitch free
    always_ff @(posedge pcie_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            scl_rel_q <= 1'b1;
            sda_rel_q <= 1'b1;
        end else begin
            scl_rel_q <= scl_o_i;
            sda_rel_q <= sda_o_i;
        end
    end

    // Open drain, the bus pull-ups provide the high level
    assign qsfpdd_i2c_scl = scl_rel_q ? 1'bz : 1'b0;
    assign qsfpdd_i2c_sda = sda_rel_q ? 1'bz : 1'b0;

    // Readback of the actual line level, so clock stretching is visible
    pin_sync #(
        .WIDTH(2)
    ) u_i2c_sync (
        .pcie_clk (pcie_clk),
        .rst_n_i  (rst_n_i),
        .async_i  ({qsfpdd_i2c_sda, qsfpdd_i2c_scl}),
        .sync_o   ({sda_i_o, scl_i_o})
    );

endmodule

// ==== rtl/reset_sync.sv ====
// Board reset synchronizer
`timescale 1ns/1ps

module reset_sync
    import board_cfg_pkg::*;
(
    input  logic pcie_clk,
    input  logic rst_n_i,
    output logic rst_sync_n_o
);

    logic [RST_SYNC_STAGES-1:0] sync_q;

    // Assert at once, release after the chain fills with ones
    always_ff @(posedge pcie_clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[RST_SYNC_STAGES-2:0], 1'b1};
        end
    end

    assign rst_sync_n_o = sync_q[RST_SYNC_STAGES-1];

endmodule

// ==== include/tb_wb_tasks.svh ====
// Wishbone bus and compare tasks
`ifndef TB_WB_TASKS_SVH
`define TB_WB_TASKS_SVH

// Drives pcie_clk-timed wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w, wb_sel
// and samples wb_ack and wb_dat_r of the including testbench

task automatic wb_cycle(input logic [WB_ADDR_W-1:0] addr, input logic we,
                        input logic [WB_DATA_W-1:0] wdat, input logic [WB_SEL_W-1:0] sel,
                        output logic [WB_DATA_W-1:0] rdat);
    int waited;
    waited = 0;
    @(posedge pcie_clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = addr;
    wb_dat_w = wdat;
    wb_sel   = sel;
    @(posedge pcie_clk);
    #1;
    // Read data is valid while ack is high
    while (!wb_ack) begin
        waited++;
        if (waited >= 8) begin
            $display("Wishbone ack did not arrive within 8 cycles");
            $display("TB FAILED");
            $fatal(1);
        end
        @(posedge pcie_clk);
        #1;
    end
    rdat = wb_dat_r;
    // The edge that ends the ack cycle takes the write
    @(posedge pcie_clk);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    // Single-cycle ack, no back-to-back pulse
    check_pins("wb_ack_o", {3'b000, wb_ack}, 4'h0);
endtask

task automatic wb_write(input logic [WB_ADDR_W-1:0] addr, input logic [WB_DATA_W-1:0] data,
                        input logic [WB_SEL_W-1:0] sel);
    logic [WB_DATA_W-1:0] unused;
    wb_cycle(addr, 1'b1, data, sel, unused);
endtask

task automatic wb_read(input logic [WB_ADDR_W-1:0] addr, output logic [WB_DATA_W-1:0] data);
    wb_cycle(addr, 1'b0, '0, '1, data);
endtask

task automatic check_word(input string name, input logic [WB_DATA_W-1:0] got,
                          input logic [WB_DATA_W-1:0] exp);
    if (got !== exp) begin
        $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
        $display("TB FAILED");
        $fatal(1);
    end
endtask

task automatic check_ver(input fw_ver_u got, input fw_ver_u exp);
    check_word("fw_ver.major", WB_DATA_W'(got.f.major), WB_DATA_W'(exp.f.major));
    check_word("fw_ver.minor", WB_DATA_W'(got.f.minor), WB_DATA_W'(exp.f.minor));
    check_word("fw_ver.patch", WB_DATA_W'(got.f.patch), WB_DATA_W'(exp.f.patch));
    check_word("fw_ver.meta", WB_DATA_W'(got.f.meta), WB_DATA_W'(exp.f.meta));
endtask

task automatic check_pins(input string name, input logic [3:0] got, input logic [3:0] exp);
    check_word(name, WB_DATA_W'(got), WB_DATA_W'(exp));
endtask

`endif

// ==== tests/tb_nic_board.sv ====
// NIC board glue logic testbench
`timescale 1ns/1ps

module tb_nic_board
    import board_cfg_pkg::*;
    import board_csr_pkg::*;
();

    localparam int CLK_HALF = 2;
    // Status pins all high, I2C lines not pulled
    localparam logic [5:0] IDLE_PINS = 6'b00_1111;
    // Three control bits in each cage byte
    localparam logic [WB_DATA_W-1:0] CTRL_BITS = 32'h0000_0707;
    localparam logic [WB_DATA_W-1:0] LED_BITS  = 32'h0000_000F;

    // pins: [3:0] {int_l[1], modprs_l[1], int_l[0], modprs_l[0]}, [4] scl pull, [5] sda pull
    typedef struct packed {
        logic [WB_ADDR_W-1:0] addr;
        logic                 we;
        logic [WB_DATA_W-1:0] data;
        logic [WB_SEL_W-1:0]  sel;
        logic [5:0]           pins;
        logic [WB_DATA_W-1:0] exp;
    } stim_t;

    logic                  pcie_clk;
    logic                  rst_n;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [WB_ADDR_W-1:0]  wb_adr;
    logic [WB_DATA_W-1:0]  wb_dat_w;
    logic [WB_SEL_W-1:0]   wb_sel;
    logic [WB_DATA_W-1:0]  wb_dat_r;
    logic                  wb_ack;
    logic [QSFPDD_CNT-1:0] modprs_l;
    logic [QSFPDD_CNT-1:0] int_l;
    wire  [QSFPDD_CNT-1:0] modsel_l;
    wire  [QSFPDD_CNT-1:0] reset_l;
    wire  [QSFPDD_CNT-1:0] lpmode;
    wire  [LED_W-1:0]      led;
    tri1                   scl;
    tri1                   sda;
    logic                  scl_pull;
    logic                  sda_pull;
    logic                  table_ready;
    integer                seed;
    logic [WB_DATA_W-1:0]  ctrl_model;
    logic [WB_DATA_W-1:0]  led_model;
    stim_t                 table_q[$];

    // Device side of the open-drain bus
    assign scl = scl_pull ? 1'b0 : 1'bz;
    assign sda = sda_pull ? 1'b0 : 1'bz;

    `include "tb_wb_tasks.svh"

    nic_board_top u_dut (
        .pcie_clk          (pcie_clk),
        .rst_n_i           (rst_n),
        .wb_cyc_i          (wb_cyc),
        .wb_stb_i          (wb_stb),
        .wb_we_i           (wb_we),
        .wb_adr_i          (wb_adr),
        .wb_dat_i          (wb_dat_w),
        .wb_sel_i          (wb_sel),
        .wb_dat_o          (wb_dat_r),
        .wb_ack_o          (wb_ack),
        .qsfpdd_modprs_l_i (modprs_l),
        .qsfpdd_int_l_i    (int_l),
        .qsfpdd_modsel_l_o (modsel_l),
        .qsfpdd_reset_l_o  (reset_l),
        .qsfpdd_lpmode_o   (lpmode),
        .qsfpdd_i2c_scl    (scl),
        .qsfpdd_i2c_sda    (sda),
        .fpga_led_o        (led)
    );

    initial begin
        pcie_clk = 1'b0;
        forever #CLK_HALF pcie_clk = ~pcie_clk;
    end

    // Byte enables widened to a bit mask
    function automatic logic [WB_DATA_W-1:0] sel_mask(input logic [WB_SEL_W-1:0] sel);
        logic [WB_DATA_W-1:0] m;
        m = '0;
        for (int b = 0; b < WB_SEL_W; b++) begin
            if (sel[b]) begin
                m[b*8 +: 8] = 8'hFF;
            end
        end
        return m;
    endfunction

    function automatic stim_t entry(input logic [WB_ADDR_W-1:0] addr, input logic we,
                                    input logic [WB_DATA_W-1:0] data,
                                    input logic [WB_SEL_W-1:0] sel, input logic [5:0] pins,
                                    input logic [WB_DATA_W-1:0] exp);
        return '{addr, we, data, sel, pins, exp};
    endfunction

    task automatic build_table();
        logic [WB_DATA_W-1:0] d;
        logic [WB_SEL_W-1:0]  s;
        logic [WB_DATA_W-1:0] m;
        logic [3:0]           stat_pins [4];
        stat_pins = '{4'b1110, 4'b0101, 4'b1001, 4'b0000};
        table_q.push_back(entry(REG_FPGA_ID, 1'b0, '0, 4'hF, IDLE_PINS, FPGA_ID));
        table_q.push_back(entry(REG_FW_VER, 1'b0, '0, 4'hF, IDLE_PINS,
                                {FW_VER_MAJOR, FW_VER_MINOR, FW_VER_PATCH, FW_VER_META}));
        table_q.push_back(entry(REG_BOARD_ID, 1'b0, '0, 4'hF, IDLE_PINS, BOARD_ID));
        table_q.push_back(entry(REG_BOARD_VER, 1'b0, '0, 4'hF, IDLE_PINS, BOARD_VER));
        // Read-only registers keep their value
        table_q.push_back(entry(REG_FPGA_ID, 1'b1, 32'hFFFF_FFFF, 4'hF, IDLE_PINS, FPGA_ID));
        table_q.push_back(entry(REG_BOARD_VER, 1'b1, 32'h1234_5678, 4'hF, IDLE_PINS, BOARD_VER));
        // Unmapped space
        table_q.push_back(entry(8'h20, 1'b0, '0, 4'hF, IDLE_PINS, '0));
        table_q.push_back(entry(8'h40, 1'b1, 32'hFFFF_FFFF, 4'hF, IDLE_PINS, '0));
        table_q.push_back(entry(8'hFC, 1'b0, '0, 4'hF, IDLE_PINS, '0));
        for (int k = 0; k < 6; k++) begin
            d = $random(seed);
            s = $random(seed);
            m = sel_mask(s) & CTRL_BITS;
            ctrl_model = (ctrl_model & ~m) | (d & m);
            table_q.push_back(entry(REG_MOD_CTRL, 1'b1, d, s, IDLE_PINS, ctrl_model));
        end
        for (int k = 0; k < 5; k++) begin
            d = $random(seed);
            s = $random(seed);
            m = sel_mask(s) & LED_BITS;
            led_model = (led_model & ~m) | (d & m);
            table_q.push_back(entry(REG_LED, 1'b1, d, s, IDLE_PINS, led_model));
        end
        // Status byte per cage, modprs_l in bit 0 and int_l in bit 1
        foreach (stat_pins[k]) begin
            table_q.push_back(entry(REG_MOD_STAT, 1'b0, '0, 4'hF, {2'b00, stat_pins[k]},
                                    {22'b0, stat_pins[k][3:2], 6'b0, stat_pins[k][1:0]}));
        end
        // A device holding a line low shows in the readback bits
        table_q.push_back(entry(REG_I2C, 1'b0, '0, 4'hF, {2'b01, 4'hF}, 32'h0000_0203));
        table_q.push_back(entry(REG_I2C, 1'b0, '0, 4'hF, {2'b10, 4'hF}, 32'h0000_0103));
        table_q.push_back(entry(REG_I2C, 1'b0, '0, 4'hF, IDLE_PINS, 32'h0000_0303));
    endtask

    task automatic apply_pins(input logic [5:0] pins);
        @(posedge pcie_clk);
        #1;
        modprs_l[0] = pins[0];
        int_l[0]    = pins[1];
        modprs_l[1] = pins[2];
        int_l[1]    = pins[3];
        scl_pull    = pins[4];
        sda_pull    = pins[5];
    endtask

    task automatic check_ctrl_pins(input logic [WB_DATA_W-1:0] exp);
        check_pins("qsfpdd_reset_l_o", {2'b00, reset_l},
                   {2'b00, exp[8 + CTRL_RESET_L_BIT], exp[CTRL_RESET_L_BIT]});
        check_pins("qsfpdd_lpmode_o", {2'b00, lpmode},
                   {2'b00, exp[8 + CTRL_LPMODE_BIT], exp[CTRL_LPMODE_BIT]});
        check_pins("qsfpdd_modsel_l_o", {2'b00, modsel_l},
                   {2'b00, exp[8 + CTRL_MODSEL_L_BIT], exp[CTRL_MODSEL_L_BIT]});
    endtask

    task automatic check_i2c_release(input logic [WB_DATA_W-1:0] wdat, input logic scl_exp,
                                     input logic sda_exp);
        logic [WB_DATA_W-1:0] rd;
        wb_write(REG_I2C, wdat, 4'h1);
        // Pad register, then the line itself
        repeat (2) @(posedge pcie_clk);
        #1;
        check_pins("qsfpdd_i2c_scl", {3'b000, scl}, {3'b000, scl_exp});
        check_pins("qsfpdd_i2c_sda", {3'b000, sda}, {3'b000, sda_exp});
        repeat (3) @(posedge pcie_clk);
        wb_read(REG_I2C, rd);
        check_word("wb_dat_o[0x18]", rd, {22'b0, sda_exp, scl_exp, 6'b0, wdat[1:0]});
    endtask

    initial begin
        logic [WB_DATA_W-1:0] rd;
        fw_ver_u              exp_ver;
        rst_n       = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        wb_sel      = '0;
        modprs_l    = '1;
        int_l       = '1;
        scl_pull    = 1'b0;
        sda_pull    = 1'b0;
        table_ready = 1'b0;
        seed        = 32'h596a_4a4e;
        ctrl_model  = 32'h0000_0505;
        led_model   = '0;
        exp_ver.f.major = FW_VER_MAJOR;
        exp_ver.f.minor = FW_VER_MINOR;
        exp_ver.f.patch = FW_VER_PATCH;
        exp_ver.f.meta  = FW_VER_META;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge pcie_clk);
        #1;
        rst_n = 1'b1;
        repeat (RST_SYNC_STAGES + 1) @(posedge pcie_clk);
        #1;
        // Deselected, out of reset, full power, LEDs off, bus released
        check_pins("wb_ack_o", {3'b000, wb_ack}, 4'h0);
        check_ctrl_pins(32'h0000_0505);
        check_pins("fpga_led_o", led, 4'h0);
        check_pins("qsfpdd_i2c_scl", {3'b000, scl}, 4'h1);
        check_pins("qsfpdd_i2c_sda", {3'b000, sda}, 4'h1);
        foreach (table_q[i]) begin
            apply_pins(table_q[i].pins);
            repeat (3) @(posedge pcie_clk);
            if (table_q[i].we) begin
                wb_write(table_q[i].addr, table_q[i].data, table_q[i].sel);
                if (table_q[i].addr == REG_MOD_CTRL) begin
                    check_ctrl_pins(table_q[i].exp);
                end else if (table_q[i].addr == REG_LED) begin
                    check_pins("fpga_led_o", led, table_q[i].exp[3:0]);
                end
            end
            wb_read(table_q[i].addr, rd);
            check_word($sformatf("wb_dat_o[0x%02h]", table_q[i].addr), rd, table_q[i].exp);
            if (table_q[i].addr == REG_FW_VER) begin
                check_ver(rd, exp_ver);
            end
        end
        check_i2c_release(32'h0000_0002, 1'b0, 1'b1);
        check_i2c_release(32'h0000_0001, 1'b1, 1'b0);
        check_i2c_release(32'h0000_0003, 1'b1, 1'b1);
        $display("TB PASSED");
        $finish;
    end

    // Budget of cycles per table entry plus reset and I2C steps
    initial begin
        wait (table_ready === 1'b1);
        repeat (table_q.size() * 20 + 100) @(posedge pcie_clk);
        $display("Watchdog expired before the test sequence finished");
        $display("TB FAILED");
        $fatal(1);
    end

endmodule

// ==== verilog.f ====
+incdir+include
rtl/board_cfg_pkg.sv
rtl/board_csr_pkg.sv
rtl/reset_sync.sv
rtl/pin_sync.sv
rtl/qsfpdd_i2c_pads.sv
rtl/board_csr.sv
rtl/nic_board_top.sv
tests/tb_nic_board.sv
